// ==== hw/cpunet_pkg.sv ====
// CPU network receive port, shared definitions
// Widths, station constants, register map and FSM encodings
`default_nettype none

package cpunet_pkg;

	// Beat and register widths
	typedef logic [31:0] word_t;
	// Valid bytes in a last beat, zero means all four
	typedef logic [1:0]  bytes_t;
	typedef logic [47:0] mac_t;
	typedef logic [6:0]  apb_addr_t;
	typedef logic [31:0] count_t;

	// Packet FIFO geometry, 64 words
	localparam int LG_FIFO    = 6;
	localparam int FIFO_DEPTH = 1 << LG_FIFO;
	// One extra bit tells full from empty
	typedef logic [LG_FIFO:0] fifo_ptr_t;

	// Station addresses
	localparam mac_t CPU_MAC   = 48'h1434_afa8_1234;
	localparam mac_t BCAST_MAC = 48'hffff_ffff_ffff;

	// CTRL bits
	localparam int CTRL_PROMISC = 0;
	localparam int CTRL_ENABLE  = 1;

	// APB register map, byte addresses
	localparam apb_addr_t REG_CTRL    = 7'h00;
	localparam apb_addr_t REG_MAC_HI  = 7'h04;
	localparam apb_addr_t REG_MAC_LO  = 7'h08;
	localparam apb_addr_t REG_RXDROPS = 7'h0C;
	localparam apb_addr_t REG_RXPKTS  = 7'h10;
	localparam apb_addr_t REG_RXSTAT  = 7'h14;
	localparam apb_addr_t REG_RXDATA  = 7'h18;

	// Filter position within a frame
	typedef enum logic [1:0] {FLT_HEAD0, FLT_HEAD1, FLT_PASS, FLT_SKIP} flt_state_t;
	// FIFO write side
	typedef enum logic [1:0] {WR_IDLE, WR_BODY, WR_DISCARD} wr_state_t;

endpackage

`default_nettype wire

// ==== hw/mac_filter.sv ====
// Destination MAC filter, first receive stage
// Passes frames for this station or broadcast, turns others into one abort
// Runt frames shorter than two beats are aborted as well
`timescale 1ns/1ps
`default_nettype none

module mac_filter (
	input  wire                  i_clk,
	input  wire                  i_reset,
	input  wire                  i_promisc,
	// Incoming stream
	input  wire                  i_valid,
	input  wire cpunet_pkg::word_t  i_data,
	input  wire cpunet_pkg::bytes_t i_bytes,
	input  wire                  i_last,
	input  wire                  i_abort,
	// Filtered stream, registered
	output logic                 o_valid,
	output cpunet_pkg::word_t    o_data,
	output cpunet_pkg::bytes_t   o_bytes,
	output logic                 o_last,
	output logic                 o_abort
);

	import cpunet_pkg::*;

	flt_state_t state;

	// Beat 0 match, kept for the beat 1 decision
	logic r_cpu_hi;
	logic r_bc_hi;

	logic w_end;
	logic w_accept;

	////////////////////////////////////////
	// Address compare
	////////////////////////////////////////

	// Packet boundary on this beat
	assign w_end = i_last || i_abort;

	// Beat 1 carries the low 16 address bits in its top half
	assign w_accept = i_promisc
		|| (r_cpu_hi && (i_data[31:16] == CPU_MAC[15:0]))
		|| (r_bc_hi && (i_data[31:16] == BCAST_MAC[15:0]));

	always_ff @(posedge i_clk) begin
		if (i_valid && (state == FLT_HEAD0)) begin
			r_cpu_hi <= (i_data == CPU_MAC[47:16]);
			r_bc_hi  <= (i_data == BCAST_MAC[47:16]);
		end
	end

	////////////////////////////////////////
	// Frame position FSM
	////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state   <= FLT_HEAD0;
			o_valid <= 1'b0;
			o_last  <= 1'b0;
			o_abort <= 1'b0;
		end else begin
			// Nothing goes out unless a beat arrives
			o_valid <= 1'b0;
			o_last  <= 1'b0;
			o_abort <= 1'b0;
			if (i_valid) begin
				case (state)
				FLT_HEAD0: begin
					o_valid <= 1'b1;
					// Runt, a frame ending on its first beat
					if (w_end)
						o_abort <= 1'b1;
					else
						state <= FLT_HEAD1;
				end
				FLT_HEAD1: begin
					o_valid <= 1'b1;
					if (i_abort) begin
						o_abort <= 1'b1;
						state   <= FLT_HEAD0;
					end else if (w_accept) begin
						o_last <= i_last;
						state  <= i_last ? FLT_HEAD0 : FLT_PASS;
					end else begin
						// Not ours, one abort then swallow the rest
						o_abort <= 1'b1;
						state   <= i_last ? FLT_HEAD0 : FLT_SKIP;
					end
				end
				FLT_PASS: begin
					o_valid <= 1'b1;
					o_last  <= i_last;
					o_abort <= i_abort;
					if (w_end)
						state <= FLT_HEAD0;
				end
				FLT_SKIP: begin
					if (w_end)
						state <= FLT_HEAD0;
				end
				default: state <= FLT_HEAD0;
				endcase
			end
		end
	end

	// Payload follows every beat
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_data  <= i_data;
			o_bytes <= i_bytes;
		end
	end

endmodule

`default_nettype wire

// ==== hw/rx_pkt_fifo.sv ====
// Receive packet FIFO, second stage
// Words are written speculatively and become visible on a good last beat
// Aborted or overflowing packets roll back and pulse one drop
`timescale 1ns/1ps
`default_nettype none

module rx_pkt_fifo (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire                     i_enable,
	// Filtered stream
	input  wire                     i_valid,
	input  wire cpunet_pkg::word_t  i_data,
	input  wire cpunet_pkg::bytes_t i_bytes,
	input  wire                     i_last,
	input  wire                     i_abort,
	// CPU read side
	input  wire                     i_pop,
	output cpunet_pkg::word_t       o_head_data,
	output cpunet_pkg::bytes_t      o_head_bytes,
	output logic                    o_head_last,
	output logic                    o_nonempty,
	// Packet event pulses
	output logic                    o_commit,
	output logic                    o_drop
);

	import cpunet_pkg::*;

	// Word storage
	word_t  mem_data  [0:FIFO_DEPTH-1];
	bytes_t mem_bytes [0:FIFO_DEPTH-1];
	logic   mem_last  [0:FIFO_DEPTH-1];

	// Speculative write, committed and read pointers
	fifo_ptr_t wr_ptr;
	fifo_ptr_t com_ptr;
	fifo_ptr_t rd_ptr;
	fifo_ptr_t fill;

	wr_state_t state;
	wr_state_t next_state;

	logic w_full;
	logic w_write;

	////////////////////////////////////////
	// Write decision
	////////////////////////////////////////

	// Words held, including the uncommitted ones
	assign fill   = wr_ptr - rd_ptr;
	// Top bit set only at exactly FIFO_DEPTH
	assign w_full = fill[LG_FIFO];

	always_comb begin
		next_state = state;
		w_write    = 1'b0;
		o_commit   = 1'b0;
		o_drop     = 1'b0;
		if (i_enable && i_valid) begin
			case (state)
			WR_IDLE, WR_BODY: begin
				if (i_abort) begin
					// Source gave up on this packet
					o_drop     = 1'b1;
					next_state = WR_IDLE;
				end else if (w_full) begin
					// No room, throw away the whole packet
					o_drop     = 1'b1;
					next_state = i_last ? WR_IDLE : WR_DISCARD;
				end else begin
					w_write = 1'b1;
					if (i_last) begin
						o_commit   = 1'b1;
						next_state = WR_IDLE;
					end else begin
						next_state = WR_BODY;
					end
				end
			end
			// Drop already counted, wait for the packet end
			WR_DISCARD: begin
				if (i_last || i_abort)
					next_state = WR_IDLE;
			end
			default: next_state = WR_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Pointers
	////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset || !i_enable) begin
			wr_ptr  <= '0;
			com_ptr <= '0;
			rd_ptr  <= '0;
			state   <= WR_IDLE;
		end else begin
			state <= next_state;
			// Rollback to the last good packet boundary
			if (o_drop)
				wr_ptr <= com_ptr;
			else if (w_write)
				wr_ptr <= wr_ptr + 1'b1;
			// Last word is written on the same edge
			if (o_commit)
				com_ptr <= wr_ptr + 1'b1;
			if (i_pop && o_nonempty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_write) begin
			mem_data[wr_ptr[LG_FIFO-1:0]]  <= i_data;
			mem_bytes[wr_ptr[LG_FIFO-1:0]] <= i_bytes;
			mem_last[wr_ptr[LG_FIFO-1:0]]  <= i_last;
		end
	end

	////////////////////////////////////////
	// Head of FIFO
	////////////////////////////////////////

	// Only committed words are visible
	assign o_nonempty   = (com_ptr != rd_ptr);
	assign o_head_data  = o_nonempty ? mem_data[rd_ptr[LG_FIFO-1:0]] : '0;
	assign o_head_bytes = o_nonempty ? mem_bytes[rd_ptr[LG_FIFO-1:0]] : '0;
	assign o_head_last  = o_nonempty ? mem_last[rd_ptr[LG_FIFO-1:0]] : 1'b0;

endmodule

`default_nettype wire

// ==== hw/rx_regs.sv ====
// APB register block for the receive port
// Control bits, station MAC, packet counters, FIFO status and data window
// Zero wait states, every transfer completes in its access cycle
`timescale 1ns/1ps
`default_nettype none

module rx_regs (
	input  wire                        i_clk,
	input  wire                        i_reset,
	// APB slave
	input  wire                        i_psel,
	input  wire                        i_penable,
	input  wire                        i_pwrite,
	input  wire cpunet_pkg::apb_addr_t i_paddr,
	input  wire cpunet_pkg::word_t     i_pwdata,
	output cpunet_pkg::word_t          o_prdata,
	// FIFO head and events
	input  wire cpunet_pkg::word_t     i_head_data,
	input  wire cpunet_pkg::bytes_t    i_head_bytes,
	input  wire                        i_head_last,
	input  wire                        i_nonempty,
	input  wire                        i_commit,
	input  wire                        i_drop,
	// Control out
	output logic                       o_enable,
	output logic                       o_promisc,
	output logic                       o_pop,
	output logic                       o_rx_int
);

	import cpunet_pkg::*;

	logic   w_wr;
	logic   w_rd;

	logic   r_enable;
	logic   r_promisc;
	count_t r_rxdrops;
	count_t r_rxpkts;

	////////////////////////////////////////
	// Bus decode
	////////////////////////////////////////

	// Access phase only, setup cycle does nothing
	assign w_wr = i_psel && i_penable && i_pwrite;
	assign w_rd = i_psel && i_penable && !i_pwrite;

	// Each RXDATA read consumes the head word
	assign o_pop = w_rd && (i_paddr == REG_RXDATA);

	////////////////////////////////////////
	// Control register
	////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_enable  <= 1'b0;
			r_promisc <= 1'b0;
		end else if (w_wr && (i_paddr == REG_CTRL)) begin
			r_enable  <= i_pwdata[CTRL_ENABLE];
			r_promisc <= i_pwdata[CTRL_PROMISC];
		end
	end

	assign o_enable  = r_enable;
	assign o_promisc = r_promisc;

	////////////////////////////////////////
	// Packet counters
	////////////////////////////////////////

	// Any write clears, the data value is ignored
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_rxdrops <= '0;
			r_rxpkts  <= '0;
		end else begin
			if (w_wr && (i_paddr == REG_RXDROPS))
				r_rxdrops <= '0;
			else if (i_drop)
				r_rxdrops <= r_rxdrops + 1'b1;

			if (w_wr && (i_paddr == REG_RXPKTS))
				r_rxpkts <= '0;
			else if (i_commit)
				r_rxpkts <= r_rxpkts + 1'b1;
		end
	end

	////////////////////////////////////////
	// Read mux
	////////////////////////////////////////

	always_comb begin
		o_prdata = '0;
		if (w_rd) begin
			case (i_paddr)
			REG_CTRL: begin
				o_prdata[CTRL_ENABLE]  = r_enable;
				o_prdata[CTRL_PROMISC] = r_promisc;
			end
			// Station address, high half in the low 16 bits
			REG_MAC_HI:  o_prdata[15:0] = CPU_MAC[47:32];
			REG_MAC_LO:  o_prdata = CPU_MAC[31:0];
			REG_RXDROPS: o_prdata = r_rxdrops;
			REG_RXPKTS:  o_prdata = r_rxpkts;
			// Status of the word about to be read
			REG_RXSTAT: begin
				o_prdata[0]   = i_nonempty;
				o_prdata[1]   = i_head_last;
				o_prdata[3:2] = i_head_bytes;
			end
			REG_RXDATA:  o_prdata = i_head_data;
			// Unmapped reads as zero
			default:     o_prdata = '0;
			endcase
		end
	end

	// Data waiting while the port is on
	assign o_rx_int = i_nonempty && r_enable;

endmodule

`default_nettype wire

// ==== hw/cpu_rx_port.sv ====
// CPU network receive port, top level
// Stream in, MAC filter, packet FIFO, APB register window
`timescale 1ns/1ps
`default_nettype none

module cpu_rx_port (
	input  wire                        i_clk,
	input  wire                        i_reset,
	// Network stream, never back-pressured
	input  wire                        i_rx_valid,
	input  wire cpunet_pkg::word_t     i_rx_data,
	input  wire cpunet_pkg::bytes_t    i_rx_bytes,
	input  wire                        i_rx_last,
	input  wire                        i_rx_abort,
	// APB slave
	input  wire                        i_psel,
	input  wire                        i_penable,
	input  wire                        i_pwrite,
	input  wire cpunet_pkg::apb_addr_t i_paddr,
	input  wire cpunet_pkg::word_t     i_pwdata,
	output cpunet_pkg::word_t          o_prdata,
	// Receive interrupt
	output logic                       o_rx_int
);

	import cpunet_pkg::*;

	// Filter to FIFO link
	logic   flt_valid;
	word_t  flt_data;
	bytes_t flt_bytes;
	logic   flt_last;
	logic   flt_abort;

	// Register block controls
	logic   enable;
	logic   promisc;
	logic   pop;

	// FIFO head and events
	word_t  head_data;
	bytes_t head_bytes;
	logic   head_last;
	logic   nonempty;
	logic   commit;
	logic   drop;

	mac_filter u_filter (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_promisc (promisc),
		.i_valid   (i_rx_valid),
		.i_data    (i_rx_data),
		.i_bytes   (i_rx_bytes),
		.i_last    (i_rx_last),
		.i_abort   (i_rx_abort),
		.o_valid   (flt_valid),
		.o_data    (flt_data),
		.o_bytes   (flt_bytes),
		.o_last    (flt_last),
		.o_abort   (flt_abort)
	);

	rx_pkt_fifo u_fifo (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_enable     (enable),
		.i_valid      (flt_valid),
		.i_data       (flt_data),
		.i_bytes      (flt_bytes),
		.i_last       (flt_last),
		.i_abort      (flt_abort),
		.i_pop        (pop),
		.o_head_data  (head_data),
		.o_head_bytes (head_bytes),
		.o_head_last  (head_last),
		.o_nonempty   (nonempty),
		.o_commit     (commit),
		.o_drop       (drop)
	);

	rx_regs u_regs (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.i_head_data  (head_data),
		.i_head_bytes (head_bytes),
		.i_head_last  (head_last),
		.i_nonempty   (nonempty),
		.i_commit     (commit),
		.i_drop       (drop),
		.o_enable     (enable),
		.o_promisc    (promisc),
		.o_pop        (pop),
		.o_rx_int     (o_rx_int)
	);

endmodule

`default_nettype wire

// ==== bench/tb_cpu_rx.sv ====
// Testbench for the CPU network receive port
// Sends frames on the stream, drains the FIFO over APB, checks a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_rx;

	import cpunet_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 5;
	localparam int SAMPLE_DELAY = 40;
	// Rough upper bound of clock cycles used by all tests
	localparam int TEST_CYCLES  = 2500;
	localparam int SEED         = 32'h6844;

	// Two foreign stations
	// The second differs only in the low 16 bits
	localparam mac_t OTHER_MAC = 48'h0250_c2a1_0033;
	localparam mac_t NEAR_MAC  = 48'h1434_afa8_1235;

	logic      i_clk;
	logic      i_reset;
	logic      i_rx_valid;
	word_t     i_rx_data;
	bytes_t    i_rx_bytes;
	logic      i_rx_last;
	logic      i_rx_abort;
	logic      i_psel;
	logic      i_penable;
	logic      i_pwrite;
	apb_addr_t i_paddr;
	word_t     i_pwdata;
	word_t     o_prdata;
	logic      o_rx_int;

	// Reference model
	logic   model_enable;
	logic   model_promisc;
	count_t exp_pkts;
	count_t exp_drops;
	// Committed unread words and their RXSTAT values
	word_t  exp_words[$];
	word_t  exp_stat[$];

	cpu_rx_port DUT (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_rx_valid (i_rx_valid),
		.i_rx_data  (i_rx_data),
		.i_rx_bytes (i_rx_bytes),
		.i_rx_last  (i_rx_last),
		.i_rx_abort (i_rx_abort),
		.i_psel     (i_psel),
		.i_penable  (i_penable),
		.i_pwrite   (i_pwrite),
		.i_paddr    (i_paddr),
		.i_pwdata   (i_pwdata),
		.o_prdata   (o_prdata),
		.o_rx_int   (o_rx_int)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// Watchdog allows about two clocks per counted test cycle
	initial begin
		flt_state_t fstate;
		#(TEST_CYCLES * 200 + 20000);
		fstate = DUT.u_filter.state;
		$display("Watchdog timeout at %0t, filter FSM in %s", $time, fstate.name());
		stop_with_failure();
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Wait for the next rising edge and the drive offset
	task automatic step();
		@(posedge i_clk);
		#DRIVE_DELAY;
	endtask

	task automatic stop_with_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input word_t got, input word_t expected);
		assert (got === expected) else begin
			$display("ERR t=%0t %s expected %h got %h", $time, name, expected, got);
			stop_with_failure();
		end
	endtask

	task automatic apb_write(input apb_addr_t addr, input word_t data);
		i_psel    = 1'b1;
		i_pwrite  = 1'b1;
		i_paddr   = addr;
		i_pwdata  = data;
		i_penable = 1'b0;
		step();
		i_penable = 1'b1;
		step();
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
	endtask

	// Data is sampled mid access cycle away from the edge
	task automatic apb_read(input apb_addr_t addr, output word_t data);
		i_psel    = 1'b1;
		i_pwrite  = 1'b0;
		i_paddr   = addr;
		i_penable = 1'b0;
		step();
		i_penable = 1'b1;
		#SAMPLE_DELAY;
		data = o_prdata;
		step();
		i_psel    = 1'b0;
		i_penable = 1'b0;
	endtask

	task automatic check_reg(input string name, input apb_addr_t addr, input word_t expected);
		word_t got;
		apb_read(addr, got);
		check_value(name, got, expected);
	endtask

	task automatic set_ctrl(input logic enable, input logic promisc);
		word_t value;
		value = '0;
		value[CTRL_ENABLE]  = enable;
		value[CTRL_PROMISC] = promisc;
		apb_write(REG_CTRL, value);
		model_enable  = enable;
		model_promisc = promisc;
		check_reg("CTRL", REG_CTRL, value);
	endtask

	task automatic check_counters();
		check_reg("RXPKTS", REG_RXPKTS, exp_pkts);
		check_reg("RXDROPS", REG_RXDROPS, exp_drops);
	endtask

	function automatic int random_len();
		return 2 + int'($urandom % 15);
	endfunction

	// Frame of len beats
	// A negative abort_at means no source abort
	task automatic send_packet(input mac_t mac, input int len, input bytes_t last_bytes,
			input int abort_at);
		word_t beats[$];
		int    n;
		logic  addr_ok;
		logic  stored;
		// Header holds the destination MAC and random payload follows
		beats.push_back(mac[47:16]);
		beats.push_back({mac[15:0], 16'($urandom)});
		for (int i = 2; i < len; i++)
			beats.push_back($urandom);
		n = (abort_at >= 0) ? abort_at + 1 : len;

		for (int i = 0; i < n; i++) begin
			i_rx_valid = 1'b1;
			i_rx_abort = (i == abort_at);
			i_rx_last  = (abort_at < 0) && (i == n - 1);
			i_rx_data  = i_rx_abort ? '0 : beats[i];
			i_rx_bytes = i_rx_last ? last_bytes : 2'd0;
			step();
		end
		i_rx_valid = 1'b0;
		i_rx_last  = 1'b0;
		i_rx_abort = 1'b0;
		i_rx_data  = '0;
		i_rx_bytes = '0;
		// Commit edge
		step();

		// A good frame for us that fits in the free space is stored
		// Anything else counts one drop
		addr_ok = model_promisc || (mac == CPU_MAC) || (mac == BCAST_MAC);
		stored  = (abort_at < 0) && (len >= 2) && addr_ok
			&& (len <= FIFO_DEPTH - exp_words.size());
		if (model_enable) begin
			if (stored) begin
				exp_pkts++;
				for (int i = 0; i < len; i++) begin
					exp_words.push_back(beats[i]);
					exp_stat.push_back((i == len - 1) ? {28'd0, last_bytes, 2'b11} : 32'd1);
				end
			end else begin
				exp_drops++;
			end
		end
		check_value("o_rx_int", word_t'(o_rx_int),
			word_t'(model_enable && (exp_words.size() != 0)));
	endtask

	// Read status then data for every committed word
	task automatic read_packets();
		while (exp_words.size() > 0) begin
			check_reg("RXSTAT", REG_RXSTAT, exp_stat.pop_front());
			check_reg("RXDATA", REG_RXDATA, exp_words.pop_front());
		end
		check_reg("RXSTAT", REG_RXSTAT, 32'd0);
		check_value("o_rx_int", word_t'(o_rx_int), 32'd0);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		i_reset       = 1'b1;
		i_rx_valid    = 1'b0;
		i_rx_data     = '0;
		i_rx_bytes    = '0;
		i_rx_last     = 1'b0;
		i_rx_abort    = 1'b0;
		i_psel        = 1'b0;
		i_penable     = 1'b0;
		i_pwrite      = 1'b0;
		i_paddr       = '0;
		i_pwdata      = '0;
		model_enable  = 1'b0;
		model_promisc = 1'b0;
		exp_pkts      = '0;
		exp_drops     = '0;
		repeat (8) @(posedge i_clk);
		#DRIVE_DELAY;
		i_reset = 1'b0;
		step();

		// Reset values
		check_reg("CTRL", REG_CTRL, 32'd0);
		check_counters();
		check_reg("RXSTAT", REG_RXSTAT, 32'd0);
		// Station 14:34:af:a8:12:34
		check_reg("MAC_HI", REG_MAC_HI, 32'h0000_1434);
		check_reg("MAC_LO", REG_MAC_LO, 32'hafa8_1234);
		check_value("o_rx_int", word_t'(o_rx_int), 32'd0);

		// Unicast and broadcast reception
		set_ctrl(1'b1, 1'b0);
		send_packet(CPU_MAC, random_len(), bytes_t'($urandom), -1);
		send_packet(BCAST_MAC, random_len(), bytes_t'($urandom), -1);
		send_packet(CPU_MAC, 2, 2'd3, -1);
		check_counters();
		read_packets();
		check_counters();

		// Foreign addresses rejected and then accepted in promiscuous mode
		send_packet(OTHER_MAC, random_len(), 2'd2, -1);
		send_packet(NEAR_MAC, random_len(), 2'd1, -1);
		check_reg("RXSTAT", REG_RXSTAT, 32'd0);
		check_counters();
		set_ctrl(1'b1, 1'b1);
		send_packet(OTHER_MAC, random_len(), 2'd2, -1);
		check_counters();
		read_packets();
		set_ctrl(1'b1, 1'b0);

		// Source abort and runt behind a committed frame
		send_packet(CPU_MAC, random_len(), 2'd0, -1);
		send_packet(CPU_MAC, 8, 2'd0, 4);
		send_packet(CPU_MAC, 1, 2'd0, -1);
		send_packet(BCAST_MAC, 6, 2'd0, 1);
		check_counters();
		read_packets();

		// Oversize frame followed by a normal one
		send_packet(CPU_MAC, 70, 2'd1, -1);
		check_reg("RXSTAT", REG_RXSTAT, 32'd0);
		check_counters();
		send_packet(CPU_MAC, random_len(), 2'd3, -1);
		check_counters();
		read_packets();

		// Counter clear by write
		send_packet(CPU_MAC, random_len(), 2'd1, -1);
		send_packet(OTHER_MAC, random_len(), 2'd1, -1);
		apb_write(REG_RXPKTS, 32'h1234_5678);
		exp_pkts = '0;
		check_counters();
		// RXPKTS nonzero again before the drop counter clear
		send_packet(CPU_MAC, random_len(), 2'd2, -1);
		apb_write(REG_RXDROPS, 32'h0000_00a5);
		exp_drops = '0;
		check_counters();
		read_packets();

		// Nothing is counted or stored while the port is disabled
		send_packet(OTHER_MAC, random_len(), 2'd0, -1);
		set_ctrl(1'b0, 1'b0);
		send_packet(CPU_MAC, random_len(), 2'd2, -1);
		send_packet(OTHER_MAC, random_len(), 2'd2, -1);
		send_packet(CPU_MAC, 8, 2'd0, 3);
		check_counters();
		check_reg("RXSTAT", REG_RXSTAT, 32'd0);
		check_value("o_rx_int", word_t'(o_rx_int), 32'd0);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/cpunet_pkg.sv
hw/mac_filter.sv
hw/rx_pkt_fifo.sv
hw/rx_regs.sv
hw/cpu_rx_port.sv
bench/tb_cpu_rx.sv

// ==== Makefile ====
# Verilator build and run for the CPU network receive port

SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP      = tb_cpu_rx
RTL_TOP  = cpu_rx_port
FILELIST = flist.f
OBJDIR   = obj_dir
PASS_MSG = *** TEST PASSED ***

.PHONY: all run lint clean

all: run

run:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
